/* perm_net_pkg.sv */
package perm_net_pkg;

	// network geometry
	localparam int SIZE        = 8;             // lanes per vector
	localparam int DATA_WIDTH  = 16;            // bits per lane
	localparam int SWITCH_NUM  = SIZE / 2;      // 2x2 switches per column
	localparam int STAGE_NUM   = 5;             // switch columns
	localparam int BUFFER_NUM  = STAGE_NUM - 1; // register layers between columns
	localparam int NET_LATENCY = BUFFER_NUM;    // input edge to output, in cycles

	// wishbone configuration port
	localparam int WB_ADDR_WIDTH = 4;
	localparam int WB_DATA_WIDTH = 8;

	// register map
	localparam int REG_STAGE0  = 0;
	localparam int REG_STAGE1  = 1;
	localparam int REG_STAGE2  = 2;
	localparam int REG_STAGE3  = 3;
	localparam int REG_STAGE4  = 4;
	localparam int REG_COMMIT  = 5;  // write copies staging to active, reads zero
	localparam int REG_ACTIVE0 = 8;  // 8..12 read back active settings

	typedef logic [DATA_WIDTH-1:0]    lane_t;    // one coefficient lane
	typedef logic [SWITCH_NUM-1:0]    sw_set_t;  // bit k set = switch k crosses
	typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;
	typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;

	typedef lane_t [SIZE-1:0]        lane_vec_t;
	typedef sw_set_t [STAGE_NUM-1:0] sw_cfg_t;   // settings of all columns

	typedef struct packed {
		logic      valid;
		lane_vec_t lanes;
	} net_vec_t;

	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		wb_addr_t adr;
		wb_data_t dat_w;
	} wb_req_t;

	typedef struct packed {
		logic     ack;
		wb_data_t dat_r;
	} wb_rsp_t;

	// Destination lane of source lane p_out in register layer "layer".
	// The first half of the layers unshuffle at shrinking block sizes,
	// the second half shuffle back at growing sizes, so straight switches
	// everywhere give the identity permutation.
	function automatic int out_sw(input int layer, input int p_out);
		int blk;
		int base;
		int q;
		blk  = (layer < BUFFER_NUM / 2) ? (SIZE >> layer) : (SIZE >> (BUFFER_NUM - 1 - layer));
		base = p_out - (p_out % blk);
		q    = p_out % blk;
		if (layer < BUFFER_NUM / 2)
			return base + (q / 2) + (q % 2) * (blk / 2); // inverse perfect shuffle
		else if (q < blk / 2)
			return base + 2 * q;                         // perfect shuffle, upper half
		else
			return base + 2 * (q - blk / 2) + 1;         // perfect shuffle, lower half
	endfunction

endpackage

/* perm_switch_stage.sv */
`timescale 1ns/100ps

module perm_switch_stage
	import perm_net_pkg::*;
(
	input  sw_set_t   i_set,   // one bit per switch
	input  lane_vec_t i_lanes,
	output lane_vec_t o_lanes
);

	// each switch k owns lanes 2k and 2k+1
	for (genvar k = 0; k < SWITCH_NUM; k++) begin : g_switch
		lane_t upper;
		lane_t lower;

		always_comb begin
			if (i_set[k]) begin
				upper = i_lanes[2*k+1]; // cross
				lower = i_lanes[2*k];
			end else begin
				upper = i_lanes[2*k];   // bar, straight through
				lower = i_lanes[2*k+1];
			end
		end

		assign o_lanes[2*k]   = upper;
		assign o_lanes[2*k+1] = lower;
	end

endmodule

/* perm_network.sv */
`timescale 1ns/100ps

module perm_network
	import perm_net_pkg::*;
(
	input  logic     clk,
	input  logic     i_rst_n,
	input  sw_cfg_t  i_cfg,   // active switch settings, applied combinationally
	input  net_vec_t i_vec,
	output net_vec_t o_vec
);

	lane_vec_t            stage_out [BUFFER_NUM]; // column outputs before wiring
	lane_vec_t            stage_in  [BUFFER_NUM]; // registered, rewired lanes
	lane_vec_t            final_lanes;
	logic [BUFFER_NUM-1:0] valid_q;

	// apply the inter-stage wiring of one layer to a whole vector
	function automatic lane_vec_t route(input int layer, input lane_vec_t lanes);
		lane_vec_t r;
		for (int p = 0; p < SIZE; p++) begin
			r[out_sw(layer, p)] = lanes[p];
		end
		return r;
	endfunction

	// valid travels alongside the lanes
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[BUFFER_NUM-2:0], i_vec.valid};
		end
	end

	// lanes are stored every cycle, idle slots just carry junk
	always_ff @(posedge clk) begin
		for (int l = 0; l < BUFFER_NUM; l++) begin
			stage_in[l] <= route(l, stage_out[l]);
		end
	end

	perm_switch_stage u_first_stage (
		.i_set   (i_cfg[0]),
		.i_lanes (i_vec.lanes),
		.o_lanes (stage_out[0])
	);

	for (genvar m = 1; m < BUFFER_NUM; m++) begin : g_middle
		perm_switch_stage u_middle_stage (
			.i_set   (i_cfg[m]),
			.i_lanes (stage_in[m-1]),
			.o_lanes (stage_out[m])
		);
	end

	perm_switch_stage u_final_stage (
		.i_set   (i_cfg[STAGE_NUM-1]),
		.i_lanes (stage_in[BUFFER_NUM-1]),
		.o_lanes (final_lanes)       // last column drives the output unregistered
	);

	assign o_vec = {valid_q[BUFFER_NUM-1], final_lanes};

	// downstream logic qualifies everything with valid, it must be clean
	a_valid_known: assert property (
		@(posedge clk) disable iff (!i_rst_n)
		!$isunknown(o_vec.valid)
	) else $error("o_vec.valid is unknown");

endmodule

/* perm_config_regs.sv */
`timescale 1ns/100ps

module perm_config_regs
	import perm_net_pkg::*;
(
	input  logic    clk,
	input  logic    i_rst_n,
	input  wb_req_t i_wb,
	output wb_rsp_t o_wb,
	output sw_cfg_t o_cfg    // settings seen by the network
);

	sw_cfg_t  staging_q;     // software-written, not yet in use
	sw_cfg_t  active_q;      // what the network routes with
	logic     ack_q;
	wb_data_t dat_r_q;
	wb_data_t rd_data;
	sw_set_t  wr_set;
	logic     access;

	// new access only when the previous one has been acknowledged
	assign access = i_wb.cyc && i_wb.stb && !ack_q;
	assign wr_set = i_wb.dat_w[SWITCH_NUM-1:0]; // upper data bits dropped

	// readback mux, unmapped addresses and commit read zero
	always_comb begin
		rd_data = '0;
		for (int s = 0; s < STAGE_NUM; s++) begin
			if (i_wb.adr == wb_addr_t'(REG_STAGE0 + s))
				rd_data = wb_data_t'(staging_q[s]);
			if (i_wb.adr == wb_addr_t'(REG_ACTIVE0 + s))
				rd_data = wb_data_t'(active_q[s]);
		end
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ack_q     <= 1'b0;
			staging_q <= '0;     // zero settings route straight through
			active_q  <= '0;
		end else begin
			ack_q <= access;
			if (access && i_wb.we) begin
				case (i_wb.adr)
					wb_addr_t'(REG_STAGE0): staging_q[0] <= wr_set;
					wb_addr_t'(REG_STAGE1): staging_q[1] <= wr_set;
					wb_addr_t'(REG_STAGE2): staging_q[2] <= wr_set;
					wb_addr_t'(REG_STAGE3): staging_q[3] <= wr_set;
					wb_addr_t'(REG_STAGE4): staging_q[4] <= wr_set;
					wb_addr_t'(REG_COMMIT): active_q     <= staging_q; // all columns at once
					default: ;                                        // read-only or unmapped
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access && !i_wb.we)
			dat_r_q <= rd_data;
	end

	assign o_wb.ack   = ack_q;
	assign o_wb.dat_r = dat_r_q;
	assign o_cfg      = active_q;

	a_ack_one_cycle: assert property (
		@(posedge clk) disable iff (!i_rst_n)
		ack_q |=> !ack_q
	) else $error("wishbone ack held for two cycles");

	// ack must answer a strobe seen on the previous edge
	a_ack_after_strobe: assert property (
		@(posedge clk) disable iff (!i_rst_n)
		$rose(ack_q) |-> $past(i_wb.cyc && i_wb.stb)
	) else $error("wishbone ack without a preceding cyc and stb");

endmodule

/* perm_net_top.sv */
`timescale 1ns/100ps

module perm_net_top
	import perm_net_pkg::*;
(
	input  logic     clk,
	input  logic     i_rst_n,
	input  wb_req_t  i_wb,    // configuration port
	output wb_rsp_t  o_wb,
	input  net_vec_t i_vec,   // one vector per cycle, no back-pressure
	output net_vec_t o_vec
);

	sw_cfg_t active_cfg;

	perm_config_regs u_config_regs (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_wb    (i_wb),
		.o_wb    (o_wb),
		.o_cfg   (active_cfg)
	);

	perm_network u_network (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_cfg   (active_cfg),
		.i_vec   (i_vec),
		.o_vec   (o_vec)
	);

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
	output logic o_clk,
	output logic o_rst_n
);

	localparam int HALF_PERIOD = 10; // 20 ns clock
	localparam int RESET_CYCLES = 3;

	initial begin
		o_clk = 1'b0;
		forever #(HALF_PERIOD) o_clk = ~o_clk;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_rst_n = 1'b1;
	end

endmodule

/* perm_net_tb.sv */
`timescale 1ns/100ps

module perm_net_tb
	import perm_net_pkg::*;
();

	localparam int WB_TIMEOUT    = 20;    // cycles to wait for ack
	localparam int DRAIN_TIMEOUT = 20;    // cycles to wait for an empty pipeline
	localparam int RUN_LIMIT     = 50000; // cycles before the watchdog fires

	logic     clk;
	logic     rst_n;
	wb_req_t  wb_req;
	wb_rsp_t  wb_rsp;
	net_vec_t vec_in;
	net_vec_t vec_out;

	lane_vec_t exp_q[$];  // expected lanes for each valid input
	int        sent_q[$]; // cycle each expected vector entered
	int        cycle;
	int        errors;
	int        tests;
	int        failed_tests;
	int        err_start;
	string     test_name;

	tb_clock_gen u_clock_gen (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	perm_net_top perm_net_top_i (
		.clk     (clk),
		.i_rst_n (rst_n),
		.i_wb    (wb_req),
		.o_wb    (wb_rsp),
		.i_vec   (vec_in),
		.o_vec   (vec_out)
	);

	initial cycle = 0;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// scoreboard sampled on the falling edge when outputs are settled
	always @(negedge clk) begin : monitor
		lane_vec_t exp_lanes;
		int        sent;
		if (rst_n && vec_out.valid === 1'b1) begin
			assert (exp_q.size() > 0) else begin
				$display("Error at %0t: o_vec valid with no vector outstanding", $time);
				errors++;
			end
			if (exp_q.size() > 0) begin
				exp_lanes = exp_q.pop_front();
				sent      = sent_q.pop_front();
				assert (cycle - sent == NET_LATENCY) else begin
					$display("Mismatch at %0t: o_vec.valid latency got %0d expected %0d",
						$time, cycle - sent, NET_LATENCY);
					errors++;
				end
				for (int l = 0; l < SIZE; l++) begin
					assert (vec_out.lanes[l] === exp_lanes[l]) else begin
						$display("Mismatch at %0t: o_vec.lanes[%0d] got %h expected %h",
							$time, l, vec_out.lanes[l], exp_lanes[l]);
						errors++;
					end
				end
			end
		end else if (rst_n && exp_q.size() > 0) begin
			// a gap in the output where a vector was due
			assert (cycle - sent_q[0] < NET_LATENCY) else begin
				$display("Error at %0t: expected output vector did not appear", $time);
				errors++;
				void'(exp_q.pop_front());
				void'(sent_q.pop_front());
			end
		end
	end

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			vec_in.valid = 1'b0;
		end
	endtask

	task automatic send_vec(input lane_vec_t lanes, input lane_vec_t expected);
		@(negedge clk);
		vec_in.valid = 1'b1;
		vec_in.lanes = lanes;
		exp_q.push_back(expected);
		sent_q.push_back(cycle);
	endtask

	task automatic drain_pipe();
		int waited;
		@(negedge clk);
		vec_in.valid = 1'b0;
		waited = 0;
		while (exp_q.size() > 0 && waited < DRAIN_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		assert (exp_q.size() == 0) else begin
			$display("Timeout at %0t: pipeline did not drain, %0d vectors missing",
				$time, exp_q.size());
			errors++;
			exp_q.delete();
			sent_q.delete();
		end
	endtask

	// one classic cycle and a check that ack drops again
	task automatic wb_access(input wb_addr_t adr, input logic we, input wb_data_t wdat,
			output wb_data_t rdat);
		int   waited;
		logic got;
		@(negedge clk);
		vec_in.valid = 1'b0;
		repeat ($urandom_range(0, 2)) @(negedge clk); // random idle gap
		wb_req.cyc   = 1'b1;
		wb_req.stb   = 1'b1;
		wb_req.we    = we;
		wb_req.adr   = adr;
		wb_req.dat_w = wdat;
		waited = 0;
		got    = 1'b0;
		while (!got && waited < WB_TIMEOUT) begin
			@(negedge clk);
			waited++;
			if (wb_rsp.ack === 1'b1)
				got = 1'b1;
		end
		rdat       = wb_rsp.dat_r;
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we  = 1'b0;
		assert (got) else begin
			$display("Timeout at %0t: no ack for access to address %h", $time, adr);
			errors++;
		end
		@(negedge clk);
		assert (wb_rsp.ack !== 1'b1) else begin
			$display("Error at %0t: ack stayed high for address %h", $time, adr);
			errors++;
		end
	endtask

	task automatic report_test();
		if (test_name != "") begin
			tests++;
			if (errors == err_start) begin
				$display("test %s: ok", test_name);
			end else begin
				failed_tests++;
				$display("test %s: %0d errors", test_name, errors - err_start);
			end
		end
		err_start = errors;
	endtask

	task automatic run_line(input string line);
		string     args;
		byte       kind;
		int        n;
		int        cnt;
		int        gaps;
		wb_addr_t  adr;
		wb_data_t  dat;
		wb_data_t  rd;
		lane_t     vi[SIZE];
		lane_t     ve[SIZE];
		lane_vec_t lanes;
		lane_vec_t expected;
		kind = line.getc(0);
		args = line.substr(1, line.len() - 1);
		case (kind)
			"T": begin
				report_test();
				test_name = line.substr(2, line.len() - 1);
			end
			"W": begin
				n = $sscanf(args, "%h %h", adr, dat);
				assert (n == 2) else begin
					$display("Error: malformed write line '%s'", line);
					errors++;
				end
				wb_access(adr, 1'b1, dat, rd);
			end
			"R": begin
				n = $sscanf(args, "%h %h", adr, dat);
				assert (n == 2) else begin
					$display("Error: malformed read line '%s'", line);
					errors++;
				end
				wb_access(adr, 1'b0, '0, rd);
				assert (rd === dat) else begin
					$display("Mismatch at %0t: o_wb.dat_r (address %h) got %h expected %h",
						$time, adr, rd, dat);
					errors++;
				end
			end
			"C": begin
				wb_access(wb_addr_t'(REG_COMMIT), 1'b1, 8'h01, rd);
				drain_pipe();
			end
			"V": begin
				n = $sscanf(args, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					vi[0], vi[1], vi[2], vi[3], vi[4], vi[5], vi[6], vi[7],
					ve[0], ve[1], ve[2], ve[3], ve[4], ve[5], ve[6], ve[7]);
				assert (n == 16) else begin
					$display("Error: malformed vector line '%s'", line);
					errors++;
				end
				for (int l = 0; l < SIZE; l++) begin
					lanes[l]    = vi[l];
					expected[l] = ve[l];
				end
				send_vec(lanes, expected);
			end
			"B": begin
				n = $sscanf(args, "%d %d", cnt, gaps);
				assert (n == 2) else begin
					$display("Error: malformed burst line '%s'", line);
					errors++;
				end
				for (int i = 0; i < cnt; i++) begin
					if (gaps != 0 && $urandom_range(0, 1) == 1)
						idle_cycles($urandom_range(1, 2)); // hole in the input stream
					for (int l = 0; l < SIZE; l++)
						lanes[l] = lane_t'($urandom);
					send_vec(lanes, lanes); // identity routing expected
				end
				drain_pipe();
			end
			"D": drain_pipe();
			"Z": begin
				@(negedge clk);
				assert (vec_out.valid === 1'b0) else begin
					$display("Mismatch at %0t: o_vec.valid got %b expected 0",
						$time, vec_out.valid);
					errors++;
				end
			end
			default: ;
		endcase
	endtask

	initial begin : main
		int    fd;
		int    n;
		int    waited;
		string line;
		wb_req       = '0;
		vec_in       = '0;
		errors       = 0;
		tests        = 0;
		failed_tests = 0;
		err_start    = 0;
		test_name    = "";
		void'($urandom(85));
		waited = 0;
		while (rst_n !== 1'b1 && waited < 10) begin
			@(negedge clk);
			waited++;
		end
		assert (rst_n === 1'b1) else begin
			$display("Timeout: reset was never released");
			errors++;
		end
		fd = $fopen("perm_net_stimulus.txt", "r");
		assert (fd != 0) else begin
			$display("Error: could not open perm_net_stimulus.txt");
			errors++;
		end
		if (fd != 0) begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				while (line.len() > 0 && (line.getc(line.len() - 1) == 8'h0a ||
						line.getc(line.len() - 1) == 8'h0d))
					line = line.substr(0, line.len() - 2);
				if (n > 0 && line.len() > 0 && line.getc(0) != "#")
					run_line(line);
			end
			$fclose(fd);
		end
		drain_pipe();
		report_test();
		$display("tests run: %0d, tests failed: %0d, errors: %0d",
			tests, failed_tests, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin : watchdog
		int n;
		n = 0;
		while (n < RUN_LIMIT) begin
			@(posedge clk);
			n++;
		end
		$display("Timeout: simulation did not finish within %0d cycles", RUN_LIMIT);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* perm_net_stimulus.txt */
# T name | W addr data | R addr expected | C commit | D drain | Z output idle
# V in0..in7 exp0..exp7 (hex lanes) | B count gaps (random lanes, identity)
T reset_and_identity
Z
V 0100 0101 0102 0103 0104 0105 0106 0107 0100 0101 0102 0103 0104 0105 0106 0107
V beef 1234 5678 9abc def0 0f0f f00f 7777 beef 1234 5678 9abc def0 0f0f f00f 7777
D
T register_access
W 0 ff
W 1 a5
W 2 3c
W 3 01
W 4 f0
R 0 0f
R 1 05
R 2 0c
R 3 01
R 4 00
R 8 00
R a 00
C
R 8 0f
R 9 05
R a 0c
R b 01
R c 00
R 5 00
R 6 00
R f 00
W 8 ff
R 8 0f
W 0 00
W 1 00
W 2 00
W 3 00
C
R 8 00
T permutations
W 4 0f
C
V 0100 0101 0102 0103 0104 0105 0106 0107 0101 0100 0103 0102 0105 0104 0107 0106
V beef 1234 5678 9abc def0 0f0f f00f 7777 1234 beef 9abc 5678 0f0f def0 7777 f00f
D
W 4 00
W 2 01
C
V 0100 0101 0102 0103 0104 0105 0106 0107 0104 0101 0102 0103 0100 0105 0106 0107
V beef 1234 5678 9abc def0 0f0f f00f 7777 def0 1234 5678 9abc beef 0f0f f00f 7777
D
W 2 00
W 1 01
C
V 0100 0101 0102 0103 0104 0105 0106 0107 0102 0101 0100 0103 0104 0105 0106 0107
V beef 1234 5678 9abc def0 0f0f f00f 7777 5678 1234 beef 9abc def0 0f0f f00f 7777
D
W 1 00
W 0 03
W 4 08
C
V 0100 0101 0102 0103 0104 0105 0106 0107 0101 0100 0103 0102 0104 0105 0107 0106
V beef 1234 5678 9abc def0 0f0f f00f 7777 1234 beef 9abc 5678 def0 0f0f 7777 f00f
D
W 0 00
W 4 00
C
T full_throughput
B 12 0
B 12 1
T atomic_commit
W 2 01
R a 00
V 0100 0101 0102 0103 0104 0105 0106 0107 0100 0101 0102 0103 0104 0105 0106 0107
V beef 1234 5678 9abc def0 0f0f f00f 7777 beef 1234 5678 9abc def0 0f0f f00f 7777
D
C
V 0100 0101 0102 0103 0104 0105 0106 0107 0104 0101 0102 0103 0100 0105 0106 0107
D

/* sim.f */
perm_net_pkg.sv
perm_switch_stage.sv
perm_network.sv
perm_config_regs.sv
perm_net_top.sv
tb_clock_gen.sv
perm_net_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the permutation network testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=perm_net_sim

verilator --binary --timing --assert \
	-f sim.f \
	--top-module perm_net_tb \
	-o "$BIN"
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

if ! grep -q "TESTBENCH PASSED" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi

exit 0
